/* fb_writer_pkg.sv */
package fb_writer_pkg;

	// ############################################################
	// Pixel and memory widths
	// ############################################################

	localparam int coord_width = 12; // Column and line counters
	localparam int pixel_width = 24; // Packed RGB
	localparam int lane_width  = 64; // Two pixels, each padded to 32 bits
	localparam int beat_width  = 256;
	localparam int beat_pixels = 8;
	localparam int addr_width  = 29; // AXI byte address

	// Line memory geometry
	localparam int beat_lanes = beat_width / lane_width;

	// Bank bit on top of the beat index within one line
	localparam int word_addr_width = coord_width - $clog2(beat_pixels) + 1;

	// ############################################################
	// Burst engine states
	// ############################################################

	typedef enum logic [2:0] {
		write_idle    = 3'd0,
		write_address = 3'd1, // awvalid up
		write_prime   = 3'd2, // Line memory read latency
		write_data    = 3'd3,
		write_done    = 3'd4
	} write_state_t;

endpackage

/* line_capture.sv */
module line_capture
	import fb_writer_pkg::*;
(
	input  logic                   axi_clock,
	input  logic                   global_reset,

	// Input pixel port
	input  logic                   input_vsync,
	input  logic                   input_line_start,
	input  logic                   input_den,
	input  logic [pixel_width-1:0] input_data_even,
	input  logic [pixel_width-1:0] input_data_odd,

	// Burst engine side
	input  logic                   read_bank,
	input  logic [coord_width-1:0] read_column,
	output logic [coord_width-1:0] write_line,
	output logic                   write_bank,
	output logic [beat_width-1:0]  line_beat
);

	localparam int lane_low  = 1; // Column bit 0 is the pixel within a pair
	localparam int lane_high = $clog2(beat_pixels) - 1;

	logic [coord_width-1:0]     write_column;
	logic                       capture;
	logic [lane_width-1:0]      pair_word;
	logic [word_addr_width-1:0] write_word;
	logic [word_addr_width-1:0] read_word;

	// ############################################################
	// Input coordinates and bank toggle
	// ############################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			write_column <= '0;
			write_line   <= '0;
			write_bank   <= 1'b1;
		end else if (input_vsync) begin
			write_column <= '0;
			write_line   <= '0;
			write_bank   <= 1'b1;
		end else if (input_line_start) begin
			write_column <= '0;
			write_line   <= write_line + 1'b1; // Wraps after 4095
			write_bank   <= ~write_bank;
		end else if (input_den) begin
			write_column <= write_column + 2'd2;
		end
	end

	// Sync pulses win over data enable
	assign capture = input_den & ~input_vsync & ~input_line_start;

	// Odd pixel on top, low byte of each half is padding
	assign pair_word = {input_data_odd, 8'h00, input_data_even, 8'h00};

	assign write_word = {write_bank, write_column[coord_width-1:lane_high+1]};
	assign read_word  = {read_bank, read_column[coord_width-1:lane_high+1]};

	// ############################################################
	// Line memory, one 64-bit column per lane
	// ############################################################

	for (genvar lane = 0; lane < beat_lanes; lane++) begin : g_lane
		logic [lane_width-1:0] lane_mem [2**word_addr_width];
		logic [lane_width-1:0] lane_q;

		always_ff @(posedge axi_clock) begin
			if (capture && (write_column[lane_high:lane_low] == lane)) begin
				lane_mem[write_word] <= pair_word;
			end
			lane_q <= lane_mem[read_word]; // One cycle behind the address
		end

		// Pair k of a beat sits in lane k from the low end
		assign line_beat[lane*lane_width +: lane_width] = lane_q;
	end

endmodule

/* burst_writer.sv */
module burst_writer
	import fb_writer_pkg::*;
#(
	parameter logic [7:0] burst_len    = 8'd16,
	parameter int         line_width   = 3840,
	parameter int         frame_height = 2160
)(
	input  logic                   axi_clock,
	input  logic                   global_reset,
	input  logic                   freeze,
	input  logic                   axi_awready,
	input  logic                   axi_wready,

	// Line capture side
	input  logic [coord_width-1:0] write_line,
	input  logic                   write_bank,
	input  logic [beat_width-1:0]  line_beat,
	output logic                   read_bank,
	output logic [coord_width-1:0] read_column,

	// AXI4 write address and data
	output logic [addr_width-1:0]  axi_awaddr,
	output logic                   axi_awvalid,
	output logic [beat_width-1:0]  axi_wdata,
	output logic                   axi_wvalid,
	output logic                   axi_wlast
);

	localparam logic [7:0]             last_beat   = burst_len - 8'd1;
	localparam logic [coord_width-1:0] column_end  = coord_width'(line_width);
	localparam logic [coord_width-1:0] column_step = coord_width'(beat_pixels);

	write_state_t           write_state;
	logic [coord_width-1:0] write_line_last;
	logic [coord_width-1:0] read_line;
	logic [7:0]             beat_count;
	logic                   beat_taken; // Beat accepted on the previous cycle
	logic                   beat_accept;
	logic                   line_settled;
	logic                   burst_ready;

	assign beat_accept  = axi_wvalid & axi_wready;
	assign line_settled = (write_line == write_line_last);

	// A line change still being taken over holds off the next burst
	assign burst_ready = line_settled && (read_column < column_end) &&
		(read_line < frame_height) && !freeze;

	// ############################################################
	// Line tracking and read column
	// ############################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			write_line_last <= '0;
			read_line       <= '1;
			read_bank       <= 1'b0;
			read_column     <= column_end; // Nothing pending
			beat_taken      <= 1'b0;
		end else begin
			write_line_last <= write_line;
			beat_taken      <= beat_accept;
			if (write_state == write_idle) begin
				if (!line_settled) begin
					read_column <= '0; // New line completed
				end
				read_line <= write_line - 1'b1;
				read_bank <= ~write_bank; // Half that just finished filling
			end else if (beat_accept) begin
				read_column <= read_column + column_step;
			end
		end
	end

	// ############################################################
	// Write burst state machine
	// ############################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			write_state <= write_idle;
			beat_count  <= '0;
		end else begin
			case (write_state)
				write_idle: begin
					if (burst_ready) begin
						write_state <= write_address;
					end
				end
				write_address: begin
					if (axi_awready) begin
						write_state <= write_prime;
						beat_count  <= '0;
					end
				end
				write_prime: begin
					write_state <= write_data;
				end
				write_data: begin
					if (beat_accept) begin
						if (beat_count == last_beat) begin
							write_state <= write_done;
						end else begin
							beat_count <= beat_count + 1'b1;
						end
					end
				end
				default: begin
					write_state <= write_idle; // Done lasts one cycle
				end
			endcase
		end
	end

	// Line times 16384 plus column times 4
	assign axi_awaddr  = addr_width'({read_line, read_column, 2'b00});
	assign axi_awvalid = (write_state == write_address);

	// Gap after each beat lets the next column come out of the line memory
	assign axi_wvalid = (write_state == write_data) && !beat_taken;
	assign axi_wlast  = axi_wvalid && (beat_count == last_beat);
	assign axi_wdata  = line_beat;

endmodule

/* fb_writer.sv */
module fb_writer
	import fb_writer_pkg::*;
#(
	parameter logic [7:0] burst_len    = 8'd16,
	parameter int         line_width   = 3840, // Pixels per line
	parameter int         frame_height = 2160
)(
	input  logic                   axi_clock,
	input  logic                   global_reset,

	// Input pixel port
	input  logic                   input_vsync,
	input  logic                   input_line_start,
	input  logic                   input_den,
	input  logic [pixel_width-1:0] input_data_even,
	input  logic [pixel_width-1:0] input_data_odd,

	input  logic                   freeze, // Blocks new bursts

	// AXI4 write address
	output logic [addr_width-1:0]  axi_awaddr,
	output logic                   axi_awvalid,
	input  logic                   axi_awready,

	// AXI4 write data
	output logic [beat_width-1:0]  axi_wdata,
	output logic                   axi_wvalid,
	output logic                   axi_wlast,
	input  logic                   axi_wready
);

	logic [coord_width-1:0] write_line;
	logic                   write_bank;
	logic                   read_bank;
	logic [coord_width-1:0] read_column;
	logic [beat_width-1:0]  line_beat;

	// ############################################################
	// Input side and ping-pong line memory
	// ############################################################

	line_capture u_line_capture (
		.axi_clock        (axi_clock),
		.global_reset     (global_reset),
		.input_vsync      (input_vsync),
		.input_line_start (input_line_start),
		.input_den        (input_den),
		.input_data_even  (input_data_even),
		.input_data_odd   (input_data_odd),
		.read_bank        (read_bank),
		.read_column      (read_column),
		.write_line       (write_line),
		.write_bank       (write_bank),
		.line_beat        (line_beat)
	);

	// ############################################################
	// AXI write burst engine
	// ############################################################

	burst_writer #(
		.burst_len    (burst_len),
		.line_width   (line_width),
		.frame_height (frame_height)
	) u_burst_writer (
		.axi_clock    (axi_clock),
		.global_reset (global_reset),
		.freeze       (freeze),
		.axi_awready  (axi_awready),
		.axi_wready   (axi_wready),
		.write_line   (write_line),
		.write_bank   (write_bank),
		.line_beat    (line_beat),
		.read_bank    (read_bank),
		.read_column  (read_column),
		.axi_awaddr   (axi_awaddr),
		.axi_awvalid  (axi_awvalid),
		.axi_wdata    (axi_wdata),
		.axi_wvalid   (axi_wvalid),
		.axi_wlast    (axi_wlast)
	);

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
	output logic axi_clock,
	output logic global_reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		axi_clock = 1'b0;
		forever #50 axi_clock = ~axi_clock; // 100 ns period
	end

	initial begin
		global_reset = 1'b1;
		repeat (8) @(posedge axi_clock);
		global_reset <= 1'b0;
	end

endmodule

/* fb_writer_monitor.sv */
module fb_writer_monitor #(
	parameter int burst_len    = 4,
	parameter int line_width   = 64,
	parameter int frame_height = 4
)(
	input  logic         axi_clock,
	input  logic         global_reset,
	input  logic         input_vsync,
	input  logic         input_line_start,
	input  logic         input_den,
	input  logic [23:0]  input_data_even,
	input  logic [23:0]  input_data_odd,
	input  logic         freeze,
	input  logic [28:0]  axi_awaddr,
	input  logic         axi_awvalid,
	input  logic         axi_awready,
	input  logic [255:0] axi_wdata,
	input  logic         axi_wvalid,
	input  logic         axi_wlast,
	input  logic         axi_wready,
	output int           error_count,
	output int           burst_count,
	output int           pending_bursts
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int bursts_per_line = line_width / (burst_len * 8);

	logic [63:0]  exp_lane [frame_height][line_width/2];
	logic [28:0]  addr_q [$];
	int           in_line;
	int           in_col;
	logic         start_seen;
	logic         in_burst;
	int           cur_line;
	int           cur_col;
	int           beat_idx;
	logic [255:0] exp_data;
	logic [28:0]  exp_addr;

	initial begin
		error_count = 0;
		burst_count = 0;
		in_burst    = 1'b0;
		start_seen  = 1'b0;
		in_line     = 0;
		in_col      = 0;
	end

	assign pending_bursts = addr_q.size() + (in_burst ? 1 : 0);

	// ############################################################
	// Expected line contents from the pixel port
	// ############################################################

	always @(posedge axi_clock) begin
		if (!global_reset) begin
			// Freeze level one cycle after the start decides if the exposed line is written
			if (start_seen && !freeze && (in_line - 1) < frame_height) begin
				for (int b = 0; b < bursts_per_line; b++) begin
					addr_q.push_back(29'((in_line - 1) * 16384 + b * burst_len * 8 * 4));
				end
			end
			start_seen = 1'b0;
			if (input_vsync) begin
				in_line = 0;
				in_col  = 0;
			end else if (input_line_start) begin
				in_line    = in_line + 1;
				in_col     = 0;
				start_seen = 1'b1;
			end else if (input_den) begin
				if (in_line < frame_height && in_col < line_width)
					exp_lane[in_line][in_col/2] = {input_data_odd, 8'h00, input_data_even, 8'h00};
				in_col = in_col + 2;
			end
		end
	end

	// ############################################################
	// AXI write side
	// ############################################################

	always @(posedge axi_clock) begin
		if (!global_reset) begin
			if (axi_awvalid && axi_awready) begin
				if (addr_q.size() == 0) begin
					$display("Burst started at address %h with no completed line pending",
						axi_awaddr);
					error_count++;
				end else begin
					exp_addr = addr_q.pop_front();
					if (axi_awaddr !== exp_addr) begin
						$display("[ERROR] axi_awaddr got %h expected %h", axi_awaddr, exp_addr);
						error_count++;
					end
					cur_line = exp_addr >> 14;
					cur_col  = (exp_addr >> 2) & 12'hfff;
					beat_idx = 0;
					in_burst = 1'b1;
				end
			end
			if (axi_wlast && !axi_wvalid) begin
				$display("wlast was high without wvalid");
				error_count++;
			end
			if (axi_wvalid && !in_burst) begin
				$display("wvalid was high outside of any burst");
				error_count++;
			end else if (axi_wvalid) begin
				// wlast belongs to the beat on offer, accepted or not
				if (axi_wlast !== (beat_idx == burst_len - 1)) begin
					$display("[ERROR] axi_wlast got %h expected %h", axi_wlast,
						beat_idx == burst_len - 1);
					error_count++;
				end
				if (axi_wready) begin
					for (int k = 0; k < 4; k++)
						exp_data[k*64 +: 64] = exp_lane[cur_line][cur_col/2 + k];
					if (axi_wdata !== exp_data) begin
						$display("[ERROR] axi_wdata got %h expected %h", axi_wdata, exp_data);
						error_count++;
					end
					cur_col  = cur_col + 8;
					beat_idx = beat_idx + 1;
					if (beat_idx == burst_len) begin
						in_burst = 1'b0;
						burst_count++;
					end
				end
			end
		end
	end

endmodule

/* fb_writer_checker.sv */
module fb_writer_checker (
	input logic axi_clock,
	input logic global_reset,
	input logic axi_awvalid,
	input logic axi_awready,
	input logic axi_wvalid,
	input logic axi_wready
);

	timeunit 1ns;
	timeprecision 1ps;

	// Address held until taken
	awvalid_held: assert property (@(posedge axi_clock) disable iff (global_reset)
		axi_awvalid && !axi_awready |=> axi_awvalid)
		else $error("awvalid dropped before awready");

	// No data while the address is still pending
	no_data_before_addr: assert property (@(posedge axi_clock) disable iff (global_reset)
		axi_awvalid |-> !axi_wvalid)
		else $error("wvalid high while awvalid pending");

	beat_gap: assert property (@(posedge axi_clock) disable iff (global_reset)
		axi_wvalid && axi_wready |=> !axi_wvalid)
		else $error("wvalid high right after an accepted beat");

endmodule

bind fb_writer fb_writer_checker u_checker (.*);

/* fb_writer_tb.sv */
module fb_writer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int burst_len    = 4;
	localparam int line_width   = 64;
	localparam int frame_height = 4;
	localparam int line_bursts  = line_width / (burst_len * 8);
	localparam int rows         = 3;
	localparam int cycle_limit  = rows * (frame_height + 1) * (line_width / 2 + 122) + 200;

	// Frozen line (-1 for none) and bursts expected in the frame
	int freeze_table [rows] = '{-1, 1, frame_height - 1};
	int burst_table  [rows] = '{frame_height * line_bursts,
		(frame_height - 1) * line_bursts, (frame_height - 1) * line_bursts};

	logic         axi_clock;
	logic         global_reset;
	logic         input_vsync;
	logic         input_line_start;
	logic         input_den;
	logic [23:0]  input_data_even;
	logic [23:0]  input_data_odd;
	logic         freeze;
	logic [28:0]  axi_awaddr;
	logic         axi_awvalid;
	logic         axi_awready = 1'b0;
	logic [255:0] axi_wdata;
	logic         axi_wvalid;
	logic         axi_wlast;
	logic         axi_wready = 1'b0;
	int           error_count;
	int           burst_count;
	int           pending_bursts;
	logic [31:0]  lfsr_state = 32'hbd7f_a413;
	logic [1:0]   aw_wait = '0;
	int           cycles = 0;

	tb_clock_gen u_clock (.axi_clock(axi_clock), .global_reset(global_reset));

	fb_writer #(
		.burst_len    (8'(burst_len)),
		.line_width   (line_width),
		.frame_height (frame_height)
	) u_dut (.*);

	fb_writer_monitor #(
		.burst_len    (burst_len),
		.line_width   (line_width),
		.frame_height (frame_height)
	) u_monitor (.*);

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return value;
	endfunction

	// ############################################################
	// AXI ready generation
	// ############################################################

	always @(posedge axi_clock) begin
		if (global_reset) begin
			axi_awready <= 1'b0;
			axi_wready  <= 1'b0;
			aw_wait     <= '0;
		end else begin
			if (axi_awvalid && !axi_awready) begin
				if (aw_wait == 0) axi_awready <= 1'b1;
				else aw_wait <= aw_wait - 1'b1;
			end else begin
				axi_awready <= 1'b0;
				aw_wait     <= 2'(random_bits(2)); // 0 to 3 cycles
			end
			axi_wready <= (random_bits(2) != 2'b11);
		end
	end

	always @(posedge axi_clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the stimulus did not finish", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic start_line(input logic raise_freeze);
		@(posedge axi_clock);
		input_line_start <= 1'b1;
		input_den        <= 1'b0;
		if (raise_freeze) freeze <= 1'b1;
		@(posedge axi_clock);
		input_line_start <= 1'b0;
		freeze           <= raise_freeze; // Drops one cycle after the following start
	endtask

	task automatic send_pixels();
		for (int i = 0; i < line_width / 2; i++) begin
			@(posedge axi_clock);
			input_den       <= 1'b1;
			input_data_even <= 24'(random_bits(24));
			input_data_odd  <= 24'(random_bits(24));
		end
		@(posedge axi_clock);
		input_den <= 1'b0;
		repeat (120) @(posedge axi_clock);
	endtask

	initial begin
		int passed;
		int failed;
		int errors_before;
		int bursts_before;
		passed = 0;
		failed = 0;
		input_vsync      <= 1'b0;
		input_line_start <= 1'b0;
		input_den        <= 1'b0;
		input_data_even  <= '0;
		input_data_odd   <= '0;
		freeze           <= 1'b0;
		@(posedge axi_clock);
		while (global_reset) @(posedge axi_clock);
		for (int row = 0; row < rows; row++) begin
			errors_before = error_count;
			bursts_before = burst_count;
			@(posedge axi_clock);
			input_vsync <= 1'b1;
			@(posedge axi_clock);
			input_vsync <= 1'b0;
			for (int line = 0; line < frame_height; line++) begin
				if (line > 0) start_line(freeze_table[row] == line - 1);
				send_pixels();
			end
			start_line(freeze_table[row] == frame_height - 1); // Exposes the last line
			repeat (120) @(posedge axi_clock);
			if (pending_bursts != 0)
				$display("Frame %0d ended with %0d bursts still missing", row, pending_bursts);
			if (burst_count - bursts_before != burst_table[row])
				$display("Frame %0d wrote %0d bursts instead of %0d", row,
					burst_count - bursts_before, burst_table[row]);
			if (error_count == errors_before && pending_bursts == 0 &&
				burst_count - bursts_before == burst_table[row]) begin
				passed++;
				$display("Frame %0d freeze line %0d: passed", row, freeze_table[row]);
			end else begin
				failed++;
				$display("Frame %0d freeze line %0d: failed", row, freeze_table[row]);
			end
		end
		$display("Frames passed %0d, failed %0d, errors %0d", passed, failed, error_count);
		if (failed == 0 && error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* fb_writer.f */
fb_writer_pkg.sv
line_capture.sv
burst_writer.sv
fb_writer.sv
tb_clock_gen.sv
fb_writer_monitor.sv
fb_writer_checker.sv
fb_writer_tb.sv

/* Makefile */
# Verilator build and run for the framebuffer writer

VERILATOR ?= verilator
TOP       ?= fb_writer_tb
LOG       ?= sim.log
FILELIST  ?= fb_writer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
